/* src/titan_pkg.sv */
// Shared address map, register offsets, widths, timing constants and state enums
`default_nettype none

package titan_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Scratch RAM region
  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h1000_0000;
  localparam int unsigned       RAM_WORDS = 256;
  localparam int unsigned       RAM_IDX_W = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] RAM_BYTES = 32'(RAM_WORDS * 4);

  // System controller region, 8 words
  localparam logic [ADDR_W-1:0] SC_BASE  = 32'h0000_2000;
  localparam logic [ADDR_W-1:0] SC_BYTES = 32'd32;
  localparam int unsigned       SC_OFF_W = 3;

  // Register byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_BOOT_E = 8'h04;
  localparam logic [7:0] REG_BOOT_P = 8'h08;
  localparam logic [7:0] REG_PLL_E  = 8'h0C;
  localparam logic [7:0] REG_PLL_P  = 8'h10;
  localparam logic [7:0] REG_STATUS = 8'h14;

  // PLL register holds ref divider [3:0] and feedback divider [15:4]
  localparam int unsigned PLL_W = 16;

  // Reset values
  localparam logic [ADDR_W-1:0] BOOT_RST    = 32'h0000_1000;
  localparam logic [PLL_W-1:0]  PLL_CFG_RST = 16'h0641;

  // Domain timing
  localparam int unsigned N_DOMAINS   = 2;
  localparam int unsigned LOCK_CYCLES = 16;
  localparam int unsigned LOCK_CNT_W  = $clog2(LOCK_CYCLES);
  localparam logic [LOCK_CNT_W-1:0] LOCK_CNT_MAX = LOCK_CNT_W'(LOCK_CYCLES - 1);
  localparam int unsigned RST_DELAY   = 4;
  localparam int unsigned RST_CNT_W   = $clog2(RST_DELAY);
  localparam logic [RST_CNT_W-1:0] RST_CNT_MAX = RST_CNT_W'(RST_DELAY - 1);

  // Host port handshake states
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT_RD,
    ACK_HI
  } host_state_e;

  // System link targets
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_SC,
    TGT_NONE
  } tgt_sel_e;

endpackage

`default_nettype wire

/* src/host_port.sv */
// Four-phase req/ack host port issuing one single-cycle link access per handshake
`default_nettype none

module host_port (
  input  wire logic                        ref_clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        req_i,
  input  wire logic                        we_i,
  input  wire logic [titan_pkg::ADDR_W-1:0] addr_i,
  input  wire logic [titan_pkg::DATA_W-1:0] wdata_i,
  output logic                             ack_o,
  output logic                             err_o,
  output logic [titan_pkg::DATA_W-1:0]     rdata_o,
  output logic                             link_vld_o,
  output logic                             link_we_o,
  output logic [titan_pkg::ADDR_W-1:0]     link_addr_o,
  output logic [titan_pkg::DATA_W-1:0]     link_wdata_o,
  input  wire logic                        link_rvld_i,
  input  wire logic [titan_pkg::DATA_W-1:0] link_rdata_i,
  input  wire logic                        link_err_i
);

  titan_pkg::host_state_e state_q;

  // Request is held in the capture registers for the link access
  always_ff @(posedge ref_clk_i) begin
    if (state_q == titan_pkg::IDLE && req_i) begin
      link_we_o    <= we_i;
      link_addr_o  <= addr_i;
      link_wdata_o <= wdata_i;
    end
  end

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= titan_pkg::IDLE;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      case (state_q)
        titan_pkg::IDLE: begin
          if (req_i) state_q <= titan_pkg::ACCESS;
        end
        titan_pkg::ACCESS: begin
          state_q <= titan_pkg::WAIT_RD;
        end
        titan_pkg::WAIT_RD: begin
          if (link_rvld_i) begin
            rdata_o <= link_rdata_i;
            err_o   <= link_err_i;
            state_q <= titan_pkg::ACK_HI;
          end
        end
        default: begin
          // Ack follows req until the host lets go
          ack_o <= req_i;
          if (!req_i) state_q <= titan_pkg::IDLE;
        end
      endcase
    end
  end

  assign link_vld_o = (state_q == titan_pkg::ACCESS);

  // A link access only follows a newly sampled request and never a held ack
  a_vld_new_req : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    link_vld_o |-> $past(req_i) && !$past(ack_o));

  // Decoder answers every access on the following cycle
  a_rvld_follows : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    link_vld_o |=> link_rvld_i);

endmodule

`default_nettype wire

/* src/sys_link_decode.sv */
// System link address decoder with target select and response mux
`default_nettype none

module sys_link_decode (
  input  wire logic                            ref_clk_i,
  input  wire logic                            arst_n_i,
  input  wire logic                            link_vld_i,
  input  wire logic                            link_we_i,
  input  wire logic [titan_pkg::ADDR_W-1:0]    link_addr_i,
  input  wire logic [titan_pkg::DATA_W-1:0]    link_wdata_i,
  output logic                                 link_rvld_o,
  output logic [titan_pkg::DATA_W-1:0]         link_rdata_o,
  output logic                                 link_err_o,
  output logic                                 ram_sel_o,
  output logic                                 ram_we_o,
  output logic [titan_pkg::RAM_IDX_W-1:0]      ram_idx_o,
  output logic [titan_pkg::DATA_W-1:0]         ram_wdata_o,
  input  wire logic [titan_pkg::DATA_W-1:0]    ram_rdata_i,
  output logic                                 sc_sel_o,
  output logic                                 sc_we_o,
  output logic [titan_pkg::SC_OFF_W-1:0]       sc_off_o,
  output logic [titan_pkg::DATA_W-1:0]         sc_wdata_o,
  input  wire logic [titan_pkg::DATA_W-1:0]    sc_rdata_i
);

  logic [titan_pkg::ADDR_W-1:0] ram_off;
  logic [titan_pkg::ADDR_W-1:0] sc_off;
  titan_pkg::tgt_sel_e          tgt;
  titan_pkg::tgt_sel_e          resp_tgt_q;

  // Offsets relative to each region base, wrap makes the low bound check free
  assign ram_off = link_addr_i - titan_pkg::RAM_BASE;
  assign sc_off  = link_addr_i - titan_pkg::SC_BASE;

  always_comb begin
    if (ram_off < titan_pkg::RAM_BYTES) tgt = titan_pkg::TGT_RAM;
    else if (sc_off < titan_pkg::SC_BYTES) tgt = titan_pkg::TGT_SC;
    else tgt = titan_pkg::TGT_NONE;
  end

  assign ram_sel_o   = link_vld_i && (tgt == titan_pkg::TGT_RAM);
  assign ram_we_o    = link_we_i;
  assign ram_idx_o   = ram_off[2 +: titan_pkg::RAM_IDX_W];
  assign ram_wdata_o = link_wdata_i;

  assign sc_sel_o   = link_vld_i && (tgt == titan_pkg::TGT_SC);
  assign sc_we_o    = link_we_i;
  assign sc_off_o   = sc_off[2 +: titan_pkg::SC_OFF_W];
  assign sc_wdata_o = link_wdata_i;

  // Target choice kept for the response cycle
  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_tgt_q  <= titan_pkg::TGT_NONE;
      link_rvld_o <= 1'b0;
    end else begin
      link_rvld_o <= link_vld_i;
      if (link_vld_i) resp_tgt_q <= tgt;
    end
  end

  always_comb begin
    case (resp_tgt_q)
      titan_pkg::TGT_RAM: link_rdata_o = ram_rdata_i;
      titan_pkg::TGT_SC:  link_rdata_o = sc_rdata_i;
      default:            link_rdata_o = '0;
    endcase
  end

  assign link_err_o = (resp_tgt_q == titan_pkg::TGT_NONE);

  // Error response exactly when the access selected no target
  a_err_no_target : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    link_rvld_o |-> link_err_o == !$past(ram_sel_o || sc_sel_o));

endmodule

`default_nettype wire

/* src/sys_ctrl.sv */
// System controller registers for boot addresses, clock enables, resets, PLLs and status
`default_nettype none

module sys_ctrl (
  input  wire logic                                ref_clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic                                sel_i,
  input  wire logic                                we_i,
  input  wire logic [titan_pkg::SC_OFF_W-1:0]      off_i,
  input  wire logic [titan_pkg::DATA_W-1:0]        wdata_i,
  output logic [titan_pkg::DATA_W-1:0]             rdata_o,
  output logic [titan_pkg::N_DOMAINS-1:0]          clk_en_o,
  output logic [titan_pkg::N_DOMAINS-1:0]          rst_rel_o,
  output logic [titan_pkg::N_DOMAINS-1:0]          pll_wr_o,
  input  wire logic [titan_pkg::N_DOMAINS-1:0]     locked_i,
  input  wire logic [titan_pkg::N_DOMAINS-1:0]     domain_rst_n_i,
  output logic [titan_pkg::ADDR_W-1:0]             boot_addr_e_o,
  output logic [titan_pkg::ADDR_W-1:0]             boot_addr_p_o
);

  logic [7:0]                      off_byte;
  logic                            wr_en;
  logic [3:0]                      ctrl_q;
  logic [titan_pkg::PLL_W-1:0]     pll_e_q;
  logic [titan_pkg::PLL_W-1:0]     pll_p_q;
  logic [titan_pkg::DATA_W-1:0]    rd_mux;

  // Word offset back to a byte offset to match the register map
  assign off_byte = 8'({off_i, 2'b00});
  assign wr_en    = sel_i && we_i;

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q        <= '0;
      boot_addr_e_o <= titan_pkg::BOOT_RST;
      boot_addr_p_o <= titan_pkg::BOOT_RST;
      pll_e_q       <= titan_pkg::PLL_CFG_RST;
      pll_p_q       <= titan_pkg::PLL_CFG_RST;
    end else if (wr_en) begin
      case (off_byte)
        titan_pkg::REG_CTRL:   ctrl_q        <= wdata_i[3:0];
        titan_pkg::REG_BOOT_E: boot_addr_e_o <= wdata_i;
        titan_pkg::REG_BOOT_P: boot_addr_p_o <= wdata_i;
        titan_pkg::REG_PLL_E:  pll_e_q       <= wdata_i[titan_pkg::PLL_W-1:0];
        titan_pkg::REG_PLL_P:  pll_p_q       <= wdata_i[titan_pkg::PLL_W-1:0];
        // Status and holes are not writable
        default: ;
      endcase
    end
  end

  always_comb begin
    case (off_byte)
      titan_pkg::REG_CTRL:   rd_mux = {28'd0, ctrl_q};
      titan_pkg::REG_BOOT_E: rd_mux = boot_addr_e_o;
      titan_pkg::REG_BOOT_P: rd_mux = boot_addr_p_o;
      titan_pkg::REG_PLL_E:  rd_mux = {16'd0, pll_e_q};
      titan_pkg::REG_PLL_P:  rd_mux = {16'd0, pll_p_q};
      titan_pkg::REG_STATUS: rd_mux = {28'd0, domain_rst_n_i, locked_i};
      default:               rd_mux = '0;
    endcase
  end

  // Read data lands one cycle after the select, old value on a write
  always_ff @(posedge ref_clk_i) begin
    if (sel_i) rdata_o <= rd_mux;
  end

  // CTRL bit pairs per domain: clock enable then reset release
  assign clk_en_o  = {ctrl_q[2], ctrl_q[0]};
  assign rst_rel_o = {ctrl_q[3], ctrl_q[1]};

  // Any PLL write restarts that domain's lock sequence
  assign pll_wr_o[0] = wr_en && (off_byte == titan_pkg::REG_PLL_E);
  assign pll_wr_o[1] = wr_en && (off_byte == titan_pkg::REG_PLL_P);

endmodule

`default_nettype wire

/* src/domain_rst_gen.sv */
// Per-domain PLL lock model and delayed reset release for the core domains
`default_nettype none

module domain_rst_gen (
  input  wire logic                            ref_clk_i,
  input  wire logic                            arst_n_i,
  input  wire logic [titan_pkg::N_DOMAINS-1:0] clk_en_i,
  input  wire logic [titan_pkg::N_DOMAINS-1:0] rst_rel_i,
  input  wire logic [titan_pkg::N_DOMAINS-1:0] pll_wr_i,
  output logic [titan_pkg::N_DOMAINS-1:0]      locked_o,
  output logic [titan_pkg::N_DOMAINS-1:0]      domain_rst_n_o
);

  genvar d;

  for (d = 0; d < titan_pkg::N_DOMAINS; d++) begin : g_dom
    logic [titan_pkg::LOCK_CNT_W-1:0] lock_cnt_q;
    logic [titan_pkg::RST_CNT_W-1:0]  rel_cnt_q;
    logic                             rel_ok;

    // Lock counter restarts on every divider change
    always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        lock_cnt_q  <= '0;
        locked_o[d] <= 1'b0;
      end else if (pll_wr_i[d]) begin
        lock_cnt_q  <= '0;
        locked_o[d] <= 1'b0;
      end else if (!locked_o[d]) begin
        if (lock_cnt_q == titan_pkg::LOCK_CNT_MAX) locked_o[d] <= 1'b1;
        else lock_cnt_q <= lock_cnt_q + 1'b1;
      end
    end

    assign rel_ok = clk_en_i[d] && rst_rel_i[d] && locked_o[d];

    // Release waits RST_DELAY cycles, assertion is immediate
    always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rel_cnt_q         <= '0;
        domain_rst_n_o[d] <= 1'b0;
      end else if (!rel_ok) begin
        rel_cnt_q         <= '0;
        domain_rst_n_o[d] <= 1'b0;
      end else if (!domain_rst_n_o[d]) begin
        if (rel_cnt_q == titan_pkg::RST_CNT_MAX) domain_rst_n_o[d] <= 1'b1;
        else rel_cnt_q <= rel_cnt_q + 1'b1;
      end
    end

    // A gated clock puts the domain back in reset by the next edge
    a_rst_with_clk_en : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
      !clk_en_i[d] |=> !domain_rst_n_o[d]);
  end

endmodule

`default_nettype wire

/* src/scratch_ram.sv */
// Word-addressed scratch RAM with registered read
`default_nettype none

module scratch_ram (
  input  wire logic                               ref_clk_i,
  input  wire logic                               sel_i,
  input  wire logic                               we_i,
  input  wire logic [titan_pkg::RAM_IDX_W-1:0]    idx_i,
  input  wire logic [titan_pkg::DATA_W-1:0]       wdata_i,
  output logic [titan_pkg::DATA_W-1:0]            rdata_o
);

  logic [titan_pkg::DATA_W-1:0] mem [titan_pkg::RAM_WORDS];

  // Read returns the old word, also on a write
  always_ff @(posedge ref_clk_i) begin
    if (sel_i) begin
      if (we_i) mem[idx_i] <= wdata_i;
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

/* src/titan_sys.sv */
// Top level joining host port, link decoder, scratch RAM, system controller and reset generator
`default_nettype none

module titan_sys (
  input  wire logic                         ref_clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         req_i,
  input  wire logic                         we_i,
  input  wire logic [titan_pkg::ADDR_W-1:0] addr_i,
  input  wire logic [titan_pkg::DATA_W-1:0] wdata_i,
  output logic                              ack_o,
  output logic                              err_o,
  output logic [titan_pkg::DATA_W-1:0]      rdata_o,
  output logic                              e_core_clk_en_o,
  output logic                              p_core_clk_en_o,
  output logic                              e_core_rst_n_o,
  output logic                              p_core_rst_n_o,
  output logic [titan_pkg::ADDR_W-1:0]      boot_addr_e_core_o,
  output logic [titan_pkg::ADDR_W-1:0]      boot_addr_p_core_o
);

  // Host port to decoder
  logic                              link_vld;
  logic                              link_we;
  logic [titan_pkg::ADDR_W-1:0]      link_addr;
  logic [titan_pkg::DATA_W-1:0]      link_wdata;
  logic                              link_rvld;
  logic [titan_pkg::DATA_W-1:0]      link_rdata;
  logic                              link_err;

  // Decoder to targets
  logic                              ram_sel;
  logic                              ram_we;
  logic [titan_pkg::RAM_IDX_W-1:0]   ram_idx;
  logic [titan_pkg::DATA_W-1:0]      ram_wdata;
  logic [titan_pkg::DATA_W-1:0]      ram_rdata;
  logic                              sc_sel;
  logic                              sc_we;
  logic [titan_pkg::SC_OFF_W-1:0]    sc_off;
  logic [titan_pkg::DATA_W-1:0]      sc_wdata;
  logic [titan_pkg::DATA_W-1:0]      sc_rdata;

  // Controller to domain reset generator
  logic [titan_pkg::N_DOMAINS-1:0]   rst_rel;
  logic [titan_pkg::N_DOMAINS-1:0]   pll_wr;
  logic [titan_pkg::N_DOMAINS-1:0]   locked;

  host_port u_host_port (
    .ref_clk_i   (ref_clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o),
    .link_vld_o  (link_vld),
    .link_we_o   (link_we),
    .link_addr_o (link_addr),
    .link_wdata_o(link_wdata),
    .link_rvld_i (link_rvld),
    .link_rdata_i(link_rdata),
    .link_err_i  (link_err)
  );

  sys_link_decode u_sys_link_decode (
    .ref_clk_i   (ref_clk_i),
    .arst_n_i    (arst_n_i),
    .link_vld_i  (link_vld),
    .link_we_i   (link_we),
    .link_addr_i (link_addr),
    .link_wdata_i(link_wdata),
    .link_rvld_o (link_rvld),
    .link_rdata_o(link_rdata),
    .link_err_o  (link_err),
    .ram_sel_o   (ram_sel),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_idx),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata),
    .sc_sel_o    (sc_sel),
    .sc_we_o     (sc_we),
    .sc_off_o    (sc_off),
    .sc_wdata_o  (sc_wdata),
    .sc_rdata_i  (sc_rdata)
  );

  scratch_ram u_scratch_ram (
    .ref_clk_i(ref_clk_i),
    .sel_i    (ram_sel),
    .we_i     (ram_we),
    .idx_i    (ram_idx),
    .wdata_i  (ram_wdata),
    .rdata_o  (ram_rdata)
  );

  // Domain vectors are ordered {P-core, E-core}
  sys_ctrl u_sys_ctrl (
    .ref_clk_i     (ref_clk_i),
    .arst_n_i      (arst_n_i),
    .sel_i         (sc_sel),
    .we_i          (sc_we),
    .off_i         (sc_off),
    .wdata_i       (sc_wdata),
    .rdata_o       (sc_rdata),
    .clk_en_o      ({p_core_clk_en_o, e_core_clk_en_o}),
    .rst_rel_o     (rst_rel),
    .pll_wr_o      (pll_wr),
    .locked_i      (locked),
    .domain_rst_n_i({p_core_rst_n_o, e_core_rst_n_o}),
    .boot_addr_e_o (boot_addr_e_core_o),
    .boot_addr_p_o (boot_addr_p_core_o)
  );

  domain_rst_gen u_domain_rst_gen (
    .ref_clk_i     (ref_clk_i),
    .arst_n_i      (arst_n_i),
    .clk_en_i      ({p_core_clk_en_o, e_core_clk_en_o}),
    .rst_rel_i     (rst_rel),
    .pll_wr_i      (pll_wr),
    .locked_o      (locked),
    .domain_rst_n_o({p_core_rst_n_o, e_core_rst_n_o})
  );

endmodule

`default_nettype wire

/* dv/titan_sys_checker.sv */
// Checker with reference model of the register map, RAM and unmapped rule, plus result reporting
`default_nettype none

module titan_sys_checker (
  input wire logic                         clk_i,
  input wire logic                         arst_n_i,
  input wire logic                         req_i,
  input wire logic                         we_i,
  input wire logic [titan_pkg::ADDR_W-1:0] addr_i,
  input wire logic [titan_pkg::DATA_W-1:0] wdata_i,
  input wire logic                         ack_i,
  input wire logic                         err_i,
  input wire logic [titan_pkg::DATA_W-1:0] rdata_i,
  input wire logic                         link_vld_i
);

  // Reference state
  logic [titan_pkg::DATA_W-1:0]  ram_mem [titan_pkg::RAM_WORDS];
  logic                          ram_ok [titan_pkg::RAM_WORDS];
  logic [3:0]                    m_ctrl;
  logic [titan_pkg::ADDR_W-1:0]  m_boot_e;
  logic [titan_pkg::ADDR_W-1:0]  m_boot_p;
  logic [titan_pkg::PLL_W-1:0]   m_pll_e;
  logic [titan_pkg::PLL_W-1:0]   m_pll_p;

  // Captured request and handshake tracking
  logic                          busy;
  logic                          done;
  int                            wait_cnt;
  int                            vld_cnt;
  logic                          cap_we;
  logic [titan_pkg::ADDR_W-1:0]  cap_addr;
  logic [titan_pkg::DATA_W-1:0]  cap_wdata;
  logic [33:0]                   exp;

  string test_name;
  int    err_cnt;
  int    test_errs;
  int    test_cnt;
  int    test_fail;

  initial begin
    for (int i = 0; i < titan_pkg::RAM_WORDS; i++) ram_ok[i] = 1'b0;
    m_ctrl    = '0;
    m_boot_e  = titan_pkg::BOOT_RST;
    m_boot_p  = titan_pkg::BOOT_RST;
    m_pll_e   = titan_pkg::PLL_CFG_RST;
    m_pll_p   = titan_pkg::PLL_CFG_RST;
    busy      = 1'b0;
    done      = 1'b0;
    wait_cnt  = 0;
    vld_cnt   = 0;
    test_name = "none";
    err_cnt   = 0;
    test_errs = 0;
    test_cnt  = 0;
    test_fail = 0;
  end

  // Returns {compare rdata, expected err, expected rdata} and applies writes
  function automatic logic [33:0] ref_access(input logic we, input logic [31:0] addr,
                                             input logic [31:0] wdata);
    logic [31:0]                    ram_off;
    logic [31:0]                    sc_off;
    logic [31:0]                    exp_rd;
    logic                           chk;
    logic [titan_pkg::RAM_IDX_W-1:0] idx;
    ram_off = addr - titan_pkg::RAM_BASE;
    sc_off  = addr - titan_pkg::SC_BASE;
    exp_rd  = '0;
    chk     = !we;
    if (addr >= titan_pkg::RAM_BASE && addr < titan_pkg::RAM_BASE + titan_pkg::RAM_BYTES) begin
      idx    = ram_off[2 +: titan_pkg::RAM_IDX_W];
      chk    = chk && ram_ok[idx];
      exp_rd = ram_mem[idx];
      if (we) begin
        ram_mem[idx] = wdata;
        ram_ok[idx]  = 1'b1;
      end
      return {chk, 1'b0, exp_rd};
    end
    if (addr >= titan_pkg::SC_BASE && addr < titan_pkg::SC_BASE + titan_pkg::SC_BYTES) begin
      case (sc_off[7:0])
        titan_pkg::REG_CTRL:   exp_rd = {28'd0, m_ctrl};
        titan_pkg::REG_BOOT_E: exp_rd = m_boot_e;
        titan_pkg::REG_BOOT_P: exp_rd = m_boot_p;
        titan_pkg::REG_PLL_E:  exp_rd = {16'd0, m_pll_e};
        titan_pkg::REG_PLL_P:  exp_rd = {16'd0, m_pll_p};
        // Status depends on lock timing and is checked by the test itself
        titan_pkg::REG_STATUS: chk = 1'b0;
        default:               exp_rd = '0;
      endcase
      if (we) begin
        case (sc_off[7:0])
          titan_pkg::REG_CTRL:   m_ctrl   = wdata[3:0];
          titan_pkg::REG_BOOT_E: m_boot_e = wdata;
          titan_pkg::REG_BOOT_P: m_boot_p = wdata;
          titan_pkg::REG_PLL_E:  m_pll_e  = wdata[15:0];
          titan_pkg::REG_PLL_P:  m_pll_p  = wdata[15:0];
          default: ;
        endcase
      end
      return {chk, 1'b0, exp_rd};
    end
    return {1'b1, 1'b1, 32'd0};
  endfunction

  task automatic check_val(input string what, input logic [31:0] expv, input logic [31:0] act);
    if (expv !== act) begin
      $display("FAILED %s %s: expected %h actual %h", test_name, what, expv, act);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic fail_note(input string what);
    $display("Error in test %s: %s", test_name, what);
    err_cnt++;
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  // Sampled on the falling edge, away from the DUT's rising-edge updates
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (!busy && req_i && !ack_i) begin
        busy      = 1'b1;
        done      = 1'b0;
        wait_cnt  = 0;
        vld_cnt   = 0;
        cap_we    = we_i;
        cap_addr  = addr_i;
        cap_wdata = wdata_i;
      end else if (busy) begin
        if (link_vld_i) vld_cnt++;
        if (!done) begin
          wait_cnt++;
          if (ack_i) begin
            done = 1'b1;
            // One falling edge before the sampling edge, then 3 edges to ack
            check_val("ack latency", 32'd3, 32'(wait_cnt - 1));
            exp = ref_access(cap_we, cap_addr, cap_wdata);
            check_val("err_o", {31'd0, exp[32]}, {31'd0, err_i});
            if (exp[33]) check_val("rdata_o", exp[31:0], rdata_i);
          end else if (wait_cnt > 20) begin
            fail_note("no ack for the request");
            busy = 1'b0;
          end
        end else if (req_i && !ack_i) begin
          fail_note("ack dropped while req was still high");
        end else if (!req_i && !ack_i) begin
          busy = 1'b0;
          check_val("link accesses", 32'd1, 32'(vld_cnt));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/titan_sys_tb.sv */
// Testbench top with clock, reset, LCG stimulus, host handshake tasks and timeout
`default_nettype none

module titan_sys_tb;

  // Roughly 150 handshakes of under 20 cycles each, with margin
  localparam int MAX_CYCLES = 4000;
  localparam logic [31:0] SC = titan_pkg::SC_BASE;

  logic        clk;
  logic        arst_n;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        ack;
  logic        err;
  logic [31:0] rdata;
  logic        e_clk_en;
  logic        p_clk_en;
  logic        e_rst_n;
  logic        p_rst_n;
  logic [31:0] boot_e;
  logic [31:0] boot_p;
  logic [31:0] lcg_state;
  int          cycles;

  titan_sys i_titan_sys (
    .ref_clk_i         (clk),
    .arst_n_i          (arst_n),
    .req_i             (req),
    .we_i              (we),
    .addr_i            (addr),
    .wdata_i           (wdata),
    .ack_o             (ack),
    .err_o             (err),
    .rdata_o           (rdata),
    .e_core_clk_en_o   (e_clk_en),
    .p_core_clk_en_o   (p_clk_en),
    .e_core_rst_n_o    (e_rst_n),
    .p_core_rst_n_o    (p_rst_n),
    .boot_addr_e_core_o(boot_e),
    .boot_addr_p_core_o(boot_p)
  );

  titan_sys_checker u_checker (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .req_i     (req),
    .we_i      (we),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .ack_i     (ack),
    .err_i     (err),
    .rdata_i   (rdata),
    .link_vld_i(i_titan_sys.link_vld)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One four-phase handshake, req held for extra cycles after ack
  task automatic host_access(input logic w, input logic [31:0] a, input logic [31:0] d,
                             input int hold, output logic [31:0] rd, output logic er);
    int n;
    @(posedge clk);
    #2;
    req   = 1'b1;
    we    = w;
    addr  = a;
    wdata = d;
    n     = 0;
    while (!ack && n < 50) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!ack) u_checker.fail_note("host saw no ack");
    rd = rdata;
    er = err;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #2;
      u_checker.check_val("ack during hold", 32'd1, {31'd0, ack});
    end
    req = 1'b0;
    n   = 0;
    while (ack && n < 50) begin
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic host_write(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] rd;
    logic        er;
    host_access(1'b1, a, d, 0, rd, er);
  endtask

  task automatic host_read(input logic [31:0] a, output logic [31:0] rd);
    logic er;
    host_access(1'b0, a, 32'd0, 0, rd, er);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] a;
    logic [31:0] d;
    logic        er;
    int          n;
    arst_n    = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    lcg_state = 32'h3108;
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;

    u_checker.begin_test("reset_values");
    u_checker.check_val("ack_o", 32'd0, {31'd0, ack});
    u_checker.check_val("err_o", 32'd0, {31'd0, err});
    u_checker.check_val("rdata_o", 32'd0, rdata);
    u_checker.check_val("clk_en", 32'd0, {30'd0, p_clk_en, e_clk_en});
    u_checker.check_val("rst_n", 32'd0, {30'd0, p_rst_n, e_rst_n});
    host_read(SC + 32'(titan_pkg::REG_BOOT_E), rd);
    host_read(SC + 32'(titan_pkg::REG_BOOT_P), rd);
    host_read(SC + 32'(titan_pkg::REG_PLL_E), rd);
    host_read(SC + 32'(titan_pkg::REG_PLL_P), rd);
    u_checker.end_test();

    u_checker.begin_test("ram_random");
    for (int i = 0; i < 32; i++) begin
      lcg_state = lcg_next(lcg_state);
      a         = titan_pkg::RAM_BASE + {22'd0, lcg_state[15:8], 2'b00};
      lcg_state = lcg_next(lcg_state);
      d         = lcg_state;
      host_write(a, d);
      host_read(a, rd);
    end
    u_checker.end_test();

    u_checker.begin_test("boot_addr");
    host_write(SC + 32'(titan_pkg::REG_BOOT_E), 32'h8000_0000);
    host_write(SC + 32'(titan_pkg::REG_BOOT_P), 32'h8001_0000);
    u_checker.check_val("boot_addr_e_core_o", 32'h8000_0000, boot_e);
    u_checker.check_val("boot_addr_p_core_o", 32'h8001_0000, boot_p);
    host_read(SC + 32'(titan_pkg::REG_BOOT_E), rd);
    host_read(SC + 32'(titan_pkg::REG_BOOT_P), rd);
    u_checker.end_test();

    u_checker.begin_test("pll_and_reset");
    host_write(SC + 32'(titan_pkg::REG_PLL_E), 32'h0000_0A23);
    host_read(SC + 32'(titan_pkg::REG_STATUS), rd);
    u_checker.check_val("E locked after PLL write", 32'd0, {31'd0, rd[0]});
    host_write(SC + 32'(titan_pkg::REG_CTRL), 32'h0000_0003);
    n = 0;
    while (!rd[0] && n < 40) begin
      host_read(SC + 32'(titan_pkg::REG_STATUS), rd);
      n++;
    end
    if (!rd[0]) u_checker.fail_note("E-core PLL never locked");
    n = 0;
    while (!rd[2] && n < 40) begin
      host_read(SC + 32'(titan_pkg::REG_STATUS), rd);
      n++;
    end
    if (!rd[2]) u_checker.fail_note("E-core domain never left reset");
    u_checker.check_val("e_core_rst_n_o", 32'd1, {31'd0, e_rst_n});
    u_checker.check_val("p_core_rst_n_o", 32'd0, {31'd0, p_rst_n});
    u_checker.check_val("e_core_clk_en_o", 32'd1, {31'd0, e_clk_en});
    // Both clocks on, E-core release taken away
    host_write(SC + 32'(titan_pkg::REG_CTRL), 32'h0000_0005);
    @(posedge clk);
    #2;
    u_checker.check_val("e_core_rst_n_o after release cleared", 32'd0, {31'd0, e_rst_n});
    u_checker.check_val("p_core_clk_en_o", 32'd1, {31'd0, p_clk_en});
    u_checker.end_test();

    u_checker.begin_test("unmapped");
    host_write(titan_pkg::RAM_BASE, 32'h0BAD_F00D);
    host_access(1'b1, 32'h0000_0000, 32'hDEAD_BEEF, 0, rd, er);
    host_access(1'b1, SC + 32'd32, 32'hDEAD_BEEF, 0, rd, er);
    host_access(1'b1, titan_pkg::RAM_BASE + titan_pkg::RAM_BYTES, 32'hDEAD_BEEF, 0, rd, er);
    host_access(1'b0, 32'hFFFF_FFFC, 32'd0, 0, rd, er);
    u_checker.check_val("err_o on unmapped read", 32'd1, {31'd0, er});
    for (int i = 0; i < 5; i++) host_read(SC + 32'(4 * i), rd);
    host_read(titan_pkg::RAM_BASE, rd);
    u_checker.end_test();

    u_checker.begin_test("req_hold");
    host_access(1'b1, titan_pkg::RAM_BASE + 32'h10, 32'h1234_5678, 10, rd, er);
    host_read(titan_pkg::RAM_BASE + 32'h10, rd);
    u_checker.end_test();

    repeat (2) @(posedge clk);
    $display("Done: %0d tests, %0d failed, %0d errors",
             u_checker.test_cnt, u_checker.test_fail, u_checker.err_cnt);
    if (u_checker.err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* titan_sys.f */
src/titan_pkg.sv
src/host_port.sv
src/sys_link_decode.sv
src/sys_ctrl.sv
src/domain_rst_gen.sv
src/scratch_ram.sv
src/titan_sys.sv
dv/titan_sys_checker.sv
dv/titan_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the titan_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f titan_sys.f --top-module titan_sys_tb -o titan_sys_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/titan_sys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
